// ==== bench/uart_props.sv ====
`timescale 1ns/10ps

module uart_props (
	input logic clk,
	input logic reset,
	input logic i_serial_out,
	input logic i_busy,
	input logic i_data_valid,
	input logic i_rx_error
);

	// an idle transmitter holds the line at the stop level
	idle_line_high: assert property (@(posedge clk) disable iff (reset)
		!i_busy |-> i_serial_out)
		else $error("serial output low while the transmitter is idle");

	error_with_valid: assert property (@(posedge clk) disable iff (reset)
		i_rx_error |-> i_data_valid)
		else $error("receive error flagged without a data valid strobe");

	// valid is a strobe, never a level
	valid_one_cycle: assert property (@(posedge clk) disable iff (reset)
		i_data_valid |=> !i_data_valid)
		else $error("data valid held high for more than one cycle");

	idle_after_reset: assert property (@(posedge clk)
		reset |=> !i_busy)
		else $error("transmitter busy in the cycle after reset");

endmodule

bind uart uart_props props_i (
	.clk          (clk),
	.reset        (reset),
	.i_serial_out (o_serial_out),
	.i_busy       (o_busy),
	.i_data_valid (o_data_valid),
	.i_rx_error   (o_rx_error)
);

// ==== bench/uart_tb.sv ====
`timescale 1ns/10ps

module uart_tb;

	import uart_cfg_pkg::*;
	import uart_frame_pkg::*;

	localparam int TX_TIMEOUT   = 200;  // cycles for o_busy to fall
	localparam int RX_TIMEOUT   = 200;  // cycles for a frame to come back
	localparam int QUIET_CYCLES = 150;

	logic       clk;
	logic       reset;
	logic       enable;
	logic [7:0] data_in;
	logic       loopback;   // 1 routes the transmitter back into the receiver
	logic       bang_line;  // line level when the bench drives frames itself
	logic       serial_in;
	logic       serial_out;
	logic       busy;
	logic [7:0] received_data;
	logic       data_valid;
	logic       rx_error;

	logic [8:0]  exp_q [$];  // {error, byte} per frame still to arrive
	logic [8:0]  exp_word;
	logic [31:0] rand_word;
	integer      seed;
	int          error_cnt;
	int          check_cnt;
	int          test_cnt;
	int          errors_before;
	logic [7:0]  fixed_bytes [4] = '{8'h00, 8'hff, 8'ha5, 8'h5a};

	assign serial_in = loopback ? serial_out : bang_line;

	uart uart_i (
		.clk             (clk),
		.reset           (reset),
		.i_enable        (enable),
		.i_data          (data_in),
		.i_serial_in     (serial_in),
		.o_serial_out    (serial_out),
		.o_busy          (busy),
		.o_received_data (received_data),
		.o_data_valid    (data_valid),
		.o_rx_error      (rx_error)
	);

	always #10 clk = ~clk;

	// parity bit that gives data plus parity an even count of ones unless PARITY_ODD is set
	function automatic logic byte_parity(input logic [7:0] data);
		return ($countones(data) % 2 == 1) ^ PARITY_ODD;
	endfunction

	function automatic logic [8:0] expect_frame(input logic [7:0] data,
		input logic flip_parity, input logic stop_bit);
		logic sent_parity;
		logic bad;

		sent_parity = byte_parity(data) ^ flip_parity;
		bad = (sent_parity != byte_parity(data)) || !stop_bit;  // byte comes through anyway
		return {bad, data};
	endfunction

	task automatic check_value(input string name, input logic [7:0] got, input logic [7:0] want);
		check_cnt++;
		if (got !== want) begin
			$display("MISMATCH %s got %h expected %h", name, got, want);
			error_cnt++;
		end
	endtask

	task automatic end_test(input string name);
		test_cnt++;
		if (error_cnt == errors_before) begin
			$display("test %0d %s: passed", test_cnt, name);
		end else begin
			$display("test %0d %s: failed with %0d errors", test_cnt, name,
				error_cnt - errors_before);
		end
		errors_before = error_cnt;
	endtask

	task automatic send_byte(input logic [7:0] data);
		@(negedge clk);
		data_in = data;
		enable  = 1'b1;
		@(negedge clk);
		enable = 1'b0;
		check_value("o_busy", 8'(busy), 8'h01);
	endtask

	task automatic wait_busy_low();
		int cnt;

		cnt = 0;
		while (busy && cnt < TX_TIMEOUT) begin
			@(negedge clk);
			cnt++;
		end
		if (busy) begin
			$display("timeout: o_busy still high after %0d cycles", TX_TIMEOUT);
			error_cnt++;
		end
	endtask

	task automatic wait_rx_drain();
		int cnt;

		cnt = 0;
		while (exp_q.size() != 0 && cnt < RX_TIMEOUT) begin
			@(negedge clk);
			cnt++;
		end
		if (exp_q.size() != 0) begin
			$display("timeout: %0d expected frames never arrived", exp_q.size());
			error_cnt++;
			exp_q.delete();
		end
	endtask

	// one bit every CLOCKS_PER_BIT cycles with the lsb first
	task automatic bang_frame(input logic [7:0] data, input logic flip_parity,
		input logic stop_bit);
		logic [FRAME_BITS-1:0] bits;

		bits = {stop_bit, byte_parity(data) ^ flip_parity, data, 1'b0};
		loopback = 1'b0;
		for (int b = 0; b < FRAME_BITS; b++) begin
			@(negedge clk);
			bang_line = bits[b];
			repeat (CLOCKS_PER_BIT - 1) @(negedge clk);
		end
		@(negedge clk);
		bang_line = 1'b1;
	endtask

	// every received frame is matched against the oldest expectation
	always @(negedge clk) begin
		if (!reset && data_valid) begin
			if (exp_q.size() == 0) begin
				$display("unexpected frame received with data %h", received_data);
				error_cnt++;
			end else begin
				exp_word = exp_q.pop_front();
				check_value("o_received_data", received_data, exp_word[7:0]);
				check_value("o_rx_error", 8'(rx_error), 8'(exp_word[8]));
			end
		end
	end

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		enable = 1'b0;
		data_in = 8'h00;
		loopback = 1'b1;
		bang_line = 1'b1;
		seed = 32'hd9c9_434e;
		error_cnt = 0;
		check_cnt = 0;
		test_cnt = 0;
		errors_before = 0;
		repeat (2) @(negedge clk);
		reset = 1'b0;

		check_value("o_busy", 8'(busy), 8'h00);
		check_value("o_data_valid", 8'(data_valid), 8'h00);
		check_value("o_rx_error", 8'(rx_error), 8'h00);
		check_value("o_serial_out", 8'(serial_out), 8'h01);
		end_test("reset values");

		for (int i = 0; i < 4; i++) begin
			exp_q.push_back(expect_frame(fixed_bytes[i], 1'b0, 1'b1));
			send_byte(fixed_bytes[i]);
			wait_busy_low();
			wait_rx_drain();
		end
		end_test("loopback fixed bytes");

		for (int i = 0; i < 20; i++) begin
			rand_word = $random(seed);
			exp_q.push_back(expect_frame(rand_word[7:0], 1'b0, 1'b1));
			send_byte(rand_word[7:0]);
			wait_busy_low();
		end
		wait_rx_drain();
		end_test("loopback random bytes");

		exp_q.push_back(expect_frame(8'h3c, 1'b0, 1'b1));
		send_byte(8'h3c);
		send_byte(8'hc3);  // lands while busy and must be dropped
		wait_busy_low();
		wait_rx_drain();
		repeat (QUIET_CYCLES) @(negedge clk);
		end_test("enable while busy");

		exp_q.push_back(expect_frame(8'h96, 1'b1, 1'b1));
		bang_frame(8'h96, 1'b1, 1'b1);
		wait_rx_drain();
		end_test("bad parity");

		exp_q.push_back(expect_frame(8'h71, 1'b0, 1'b0));
		bang_frame(8'h71, 1'b0, 1'b0);
		wait_rx_drain();
		exp_q.push_back(expect_frame(8'he4, 1'b0, 1'b1));
		bang_frame(8'he4, 1'b0, 1'b1);
		wait_rx_drain();
		end_test("bad stop bit then good frame");

		$display("tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, error_cnt);
		if (error_cnt == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

// ==== design/uart.sv ====
`timescale 1ns/10ps

module uart (
	input  logic                               clk,
	input  logic                               reset,
	input  logic                               i_enable,     // one-cycle start strobe
	input  logic [uart_cfg_pkg::DATA_BITS-1:0] i_data,
	input  logic                               i_serial_in,
	output logic                               o_serial_out,
	output logic                               o_busy,
	output logic [uart_cfg_pkg::DATA_BITS-1:0] o_received_data,
	output logic                               o_data_valid,
	output logic                               o_rx_error
);

	logic baud_tick;  // transmit bit boundary, the receiver keeps its own timing

	uart_baud_gen baud_gen_i (
		.clk         (clk),
		.reset       (reset),
		.o_baud_tick (baud_tick)
	);

	uart_tx tx_i (
		.clk          (clk),
		.reset        (reset),
		.i_baud_tick  (baud_tick),
		.i_enable     (i_enable),
		.i_data       (i_data),
		.o_serial_out (o_serial_out),
		.o_busy       (o_busy)
	);

	// the serial input is a separate port, looping it back is up to the user
	uart_rx rx_i (
		.clk             (clk),
		.reset           (reset),
		.i_serial_in     (i_serial_in),
		.o_received_data (o_received_data),
		.o_data_valid    (o_data_valid),
		.o_rx_error      (o_rx_error)
	);

endmodule

// ==== design/uart_baud_gen.sv ====
`timescale 1ns/10ps

module uart_baud_gen (
	input  logic clk,
	input  logic reset,
	output logic o_baud_tick
);

	import uart_cfg_pkg::*;

	logic [CYC_CNT_W-1:0] div_cnt;  // position inside the current bit period
	logic                 wrap;

	assign wrap = (div_cnt == CYC_CNT_W'(CLOCKS_PER_BIT - 1));

	// the tick is registered, so its first pulse lands a full period
	// after reset is released
	always_ff @(posedge clk) begin
		if (reset) begin
			div_cnt     <= '0;
			o_baud_tick <= 1'b0;
		end else begin
			o_baud_tick <= wrap;
			if (wrap) begin
				div_cnt <= '0;
			end else begin
				div_cnt <= div_cnt + 1'b1;
			end
		end
	end

endmodule

// ==== design/uart_cfg_pkg.sv ====
package uart_cfg_pkg;

	// serial line timing and frame sizing

	localparam int DATA_BITS = 8;  // payload bits per frame

	localparam int CLOCKS_PER_BIT = 8;  // system clocks per serial bit

	localparam int HALF_BIT = CLOCKS_PER_BIT / 2;  // receiver sample point

	localparam int CYC_CNT_W = $clog2(CLOCKS_PER_BIT);  // width of the in-bit cycle counters

	localparam int SYNC_STAGES = 3;  // flops in front of the receiver

	localparam int BIT_CNT_W = 4;  // counts up to a full frame of 11 bits

endpackage

// ==== design/uart_frame_pkg.sv ====
package uart_frame_pkg;

	import uart_cfg_pkg::*;

	localparam int FRAME_BITS = DATA_BITS + 3;  // start, data, parity, stop

	// 0 selects even parity, 1 selects odd parity
	localparam logic PARITY_ODD = 1'b0;

	// the same word seen as a serial bit vector or as frame fields
	// bit 0 is the start bit and is the first one on the line
	typedef union packed {
		logic [FRAME_BITS-1:0] bits;  // shifted lsb first
		struct packed {
			logic                 stop;    // always 1 on a good frame
			logic                 parity;  // covers the data bits only
			logic [DATA_BITS-1:0] data;
			logic                 start;   // always 0
		} fields;
	} uart_frame_t;

	// parity bit that goes with a data byte
	function automatic logic frame_parity(input logic [DATA_BITS-1:0] data);
		logic p;

		p = ^data;  // 1 when the number of ones is odd
		return p ^ PARITY_ODD;
	endfunction

endpackage

// ==== design/uart_rx.sv ====
`timescale 1ns/10ps

module uart_rx (
	input  logic                               clk,
	input  logic                               reset,
	input  logic                               i_serial_in,
	output logic [uart_cfg_pkg::DATA_BITS-1:0] o_received_data,
	output logic                               o_data_valid,
	output logic                               o_rx_error
);

	import uart_cfg_pkg::*;
	import uart_frame_pkg::*;

	localparam logic [1:0] RX_IDLE  = 2'd0;
	localparam logic [1:0] RX_START = 2'd1;  // waiting for the middle of the start bit
	localparam logic [1:0] RX_DATA  = 2'd2;  // data bits and parity
	localparam logic [1:0] RX_STOP  = 2'd3;

	logic [SYNC_STAGES-1:0] sync_q;       // metastability chain, oldest bit on top
	logic                   rx_line;      // synchronized serial input
	logic                   line_prev;
	logic                   line_fall;

	logic [1:0]             state;
	logic [CYC_CNT_W-1:0]   cyc_cnt;      // clocks since the last sample point
	logic [BIT_CNT_W-1:0]   bit_cnt;      // samples taken in RX_DATA
	logic                   half_bit;
	logic                   full_bit;

	logic                   sample_en;    // take rx_line into the frame
	logic                   stop_sample;  // last sample of the frame
	uart_frame_t            frame_q;      // bits gathered so far, lsb first
	uart_frame_t            frame_in;     // frame_q with the current sample added
	logic                   parity_bad;
	logic                   frame_bad;

	assign rx_line   = sync_q[SYNC_STAGES-1];
	assign line_fall = line_prev && !rx_line;

	// the line idles high, so the chain resets to ones
	always_ff @(posedge clk) begin
		if (reset) begin
			sync_q    <= '1;
			line_prev <= 1'b1;
		end else begin
			sync_q    <= {sync_q[SYNC_STAGES-2:0], i_serial_in};
			line_prev <= rx_line;
		end
	end

	assign half_bit = (cyc_cnt == CYC_CNT_W'(HALF_BIT - 1));
	assign full_bit = (cyc_cnt == CYC_CNT_W'(CLOCKS_PER_BIT - 1));

	assign sample_en   = ((state == RX_START) && half_bit) ||
	                     ((state == RX_DATA) && full_bit) || stop_sample;
	assign stop_sample = (state == RX_STOP) && full_bit;

	// new bit enters at the top, so after a full frame the start bit sits at bit 0
	assign frame_in.bits = {rx_line, frame_q.bits[FRAME_BITS-1:1]};

	assign parity_bad = (frame_in.fields.parity != frame_parity(frame_in.fields.data));
	assign frame_bad  = parity_bad || !frame_in.fields.stop;

	always_ff @(posedge clk) begin
		if (reset) begin
			state        <= RX_IDLE;
			cyc_cnt      <= '0;
			bit_cnt      <= '0;
			o_data_valid <= 1'b0;
			o_rx_error   <= 1'b0;
		end else begin
			o_data_valid <= 1'b0;  // both flags are single-cycle strobes
			o_rx_error   <= 1'b0;
			case (state)
				RX_IDLE: begin
					cyc_cnt <= '0;
					if (line_fall) begin
						state <= RX_START;
					end
				end
				RX_START: begin
					if (half_bit) begin
						cyc_cnt <= '0;
						bit_cnt <= '0;
						state   <= rx_line ? RX_IDLE : RX_DATA;  // high again means a glitch
					end else begin
						cyc_cnt <= cyc_cnt + 1'b1;
					end
				end
				RX_DATA: begin
					if (full_bit) begin
						cyc_cnt <= '0;
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == BIT_CNT_W'(DATA_BITS)) begin
							state <= RX_STOP;  // that sample was the parity bit
						end
					end else begin
						cyc_cnt <= cyc_cnt + 1'b1;
					end
				end
				RX_STOP: begin
					if (full_bit) begin
						o_data_valid <= 1'b1;
						o_rx_error   <= frame_bad;
						state        <= RX_IDLE;
					end else begin
						cyc_cnt <= cyc_cnt + 1'b1;
					end
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

	// received byte stays put until the next frame completes
	always_ff @(posedge clk) begin
		if (sample_en) begin
			frame_q <= frame_in;
		end
		if (stop_sample) begin
			o_received_data <= frame_in.fields.data;
		end
	end

endmodule

// ==== design/uart_tx.sv ====
`timescale 1ns/10ps

module uart_tx (
	input  logic                               clk,
	input  logic                               reset,
	input  logic                               i_baud_tick,
	input  logic                               i_enable,
	input  logic [uart_cfg_pkg::DATA_BITS-1:0] i_data,
	output logic                               o_serial_out,
	output logic                               o_busy
);

	import uart_cfg_pkg::*;
	import uart_frame_pkg::*;

	uart_frame_t          frame_d;        // frame built from the input byte
	uart_frame_t          frame_q;        // remaining bits, lsb is next on the line
	logic [BIT_CNT_W-1:0] bit_cnt;        // bits already driven onto the line
	logic                 accept;         // start request taken this cycle
	logic                 shift;          // a bit boundary inside a frame
	logic                 last_bit_done;  // stop bit has been held one period

	always_comb begin
		frame_d.fields.start  = 1'b0;
		frame_d.fields.data   = i_data;
		frame_d.fields.parity = frame_parity(i_data);
		frame_d.fields.stop   = 1'b1;
	end

	assign accept        = !o_busy && i_enable;  // requests while busy are dropped
	assign shift         = o_busy && i_baud_tick;
	assign last_bit_done = (bit_cnt == BIT_CNT_W'(FRAME_BITS));

	// control path
	always_ff @(posedge clk) begin
		if (reset) begin
			o_busy       <= 1'b0;
			o_serial_out <= 1'b1;  // idle line is high
			bit_cnt      <= '0;
		end else if (accept) begin
			o_busy  <= 1'b1;
			bit_cnt <= '0;
		end else if (shift) begin
			if (last_bit_done) begin
				o_busy       <= 1'b0;
				o_serial_out <= 1'b1;
			end else begin
				o_serial_out <= frame_q.bits[0];
				bit_cnt      <= bit_cnt + 1'b1;
			end
		end
	end

	// frame shift register, ones fill in from the top behind the stop bit
	always_ff @(posedge clk) begin
		if (accept) begin
			frame_q <= frame_d;
		end else if (shift) begin
			frame_q.bits <= {1'b1, frame_q.bits[FRAME_BITS-1:1]};
		end
	end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the UART testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -f vlog.f --top-module uart_tb -Mdir obj_dir \
	> "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
	cat "$BUILD_LOG"
	echo "build failed"
	exit 1
fi

./obj_dir/Vuart_tb > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
	# a failed assertion stops the simulator with a nonzero status
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "ERRORS FOUND" "$SIM_LOG"; then
	exit 1
fi
exit 0

// ==== vlog.f ====
design/uart_cfg_pkg.sv
design/uart_frame_pkg.sv
design/uart_baud_gen.sv
design/uart_tx.sv
design/uart_rx.sv
design/uart.sv
bench/uart_props.sv
bench/uart_tb.sv
